// File: Bender.yml
package:
  name: memsystem

sources:
  - src/memSysPkg.sv
  - src/memBusIf.sv
  - src/cacheIf.sv
  - src/cacheController.sv
  - src/cacheStore.sv
  - src/bankedMem.sv
  - src/memSystem.sv
  - target: test
    files:
      - verification/memSystemTb.sv

// File: memSystem.f
src/memSysPkg.sv
src/memBusIf.sv
src/cacheIf.sv
src/cacheController.sv
src/cacheStore.sv
src/bankedMem.sv
src/memSystem.sv
verification/memSystemTb.sv

// File: src/bankedMem.sv
/*
 * Four-way word-interleaved main memory.
 * Each bank has a busy down-counter; reads return through
 * a BankLatency-stage shift line.
 */
`default_nettype none

module bankedMem #(
    parameter int BankLatency = 2
) (
    input  logic clk,
    input  logic rstN,
    memBusIf.mem memBus
);

    localparam int NumBanks  = memSysPkg::NumBanks;
    localparam int BankWords = memSysPkg::BankWords;
    localparam int CntWidth  = $clog2(BankLatency + 1);

    memSysPkg::dataT     words    [NumBanks][BankWords];
    logic [CntWidth-1:0] busyCnt  [NumBanks];
    memSysPkg::dataT     retData  [BankLatency];
    logic [BankLatency-1:0] retValid;

    memSysPkg::bankT     sel;
    memSysPkg::bankAddrT bankAddr;
    memSysPkg::bankMaskT busyMask;
    memSysPkg::bankMaskT accept;
    logic                rdAccept;
    logic                wrAccept;

    assign sel      = memSysPkg::addrBank(memBus.addr);
    assign bankAddr = memSysPkg::addrBankWord(memBus.addr);
    assign rdAccept = memBus.rd && !busyMask[sel];
    assign wrAccept = memBus.wr && !busyMask[sel];  // Strobes to a busy bank are dropped

    always_comb begin
        for (int b = 0; b < NumBanks; b++)
            busyMask[b] = (busyCnt[b] != '0);
    end

    always_comb begin
        accept      = '0;
        accept[sel] = rdAccept || wrAccept;
    end

    // Memory starts cleared
    initial begin
        for (int b = 0; b < NumBanks; b++)
            for (int w = 0; w < BankWords; w++)
                words[b][w] = '0;
    end

    always_ff @(posedge clk) begin
        if (wrAccept)
            words[sel][bankAddr] <= memBus.wrData;
    end

    // Busy for BankLatency cycles after an accepted strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int b = 0; b < NumBanks; b++)
                busyCnt[b] <= '0;
        end else begin
            for (int b = 0; b < NumBanks; b++) begin
                if (accept[b])
                    busyCnt[b] <= CntWidth'(BankLatency);
                else if (busyCnt[b] != '0)
                    busyCnt[b] <= busyCnt[b] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            retValid <= '0;
        end else begin
            retValid[0] <= rdAccept;
            for (int s = 1; s < BankLatency; s++)
                retValid[s] <= retValid[s-1];
        end
    end

    always_ff @(posedge clk) begin
        retData[0] <= words[sel][bankAddr];   // Captured every cycle, valid bit qualifies
        for (int s = 1; s < BankLatency; s++)
            retData[s] <= retData[s-1];
    end

    assign memBus.busy    = busyMask;
    assign memBus.rdData  = retData[BankLatency-1];
    assign memBus.rdValid = retValid[BankLatency-1];

endmodule

`default_nettype wire

// File: src/cacheController.sv
/*
 * Cache controller FSM.
 * Checks tags, fills missing lines from the four banks,
 * writes through to memory and refuses odd addresses.
 */
`default_nettype none

module cacheController (
    input  logic              clk,
    input  logic              rstN,
    input  memSysPkg::addrT   addr,
    input  memSysPkg::dataT   dataIn,
    input  logic              rd,
    input  logic              wr,
    output memSysPkg::dataT   dataOut,
    output logic              done,
    output logic              stall,
    output logic              cacheHit,
    output logic              err,
    memBusIf.ctrl             memBus,
    cacheIf.ctrl              cache
);

    typedef enum logic [2:0] {
        Idle,
        CompareTag,
        IssueFill,
        AwaitFill,
        WriteMem,
        Reply
    } ctrlStateT;

    ctrlStateT         state;
    ctrlStateT         nextState;
    memSysPkg::offsetT issueCnt;   // Next bank to strobe during a fill
    memSysPkg::offsetT retCnt;     // Offset of the next returned word
    memSysPkg::bankT   reqBank;
    logic              missFlag;   // Current read started with a miss
    logic              replyLast;
    logic              reqSeen;
    logic              filling;
    logic              issueGo;
    logic              writeGo;

    assign reqBank = memSysPkg::addrBank(addr);
    assign reqSeen = (rd || wr) && !replyLast;  // Caller still holds request right after done

    // Returns can arrive while later banks are still being strobed
    assign filling = (state == IssueFill) || (state == AwaitFill);
    assign issueGo = (state == IssueFill) && !memBus.busy[issueCnt];
    assign writeGo = (state == WriteMem) && !memBus.busy[reqBank];

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (reqSeen) begin
                    if (addr[0])
                        nextState = Reply;
                    else if (rd)
                        nextState = CompareTag;
                    else
                        nextState = WriteMem;
                end
            end
            CompareTag: nextState = cache.hit ? Reply : IssueFill;
            IssueFill: begin
                if (issueGo && (issueCnt == memSysPkg::offsetT'(memSysPkg::NumBanks - 1)))
                    nextState = AwaitFill;
            end
            AwaitFill: begin
                if (memBus.rdValid && (retCnt == memSysPkg::offsetT'(memSysPkg::NumBanks - 1)))
                    nextState = CompareTag;  // Line now present, lookup hits
            end
            WriteMem: if (writeGo) nextState = Reply;
            Reply:    nextState = Idle;
            default:  nextState = Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= Idle;
            issueCnt  <= '0;
            retCnt    <= '0;
            missFlag  <= 1'b0;
            replyLast <= 1'b0;
            cacheHit  <= 1'b0;
            err       <= 1'b0;
        end else begin
            state     <= nextState;
            replyLast <= (state == Reply);
            if (issueGo)
                issueCnt <= issueCnt + 1'b1;  // Wraps to zero after bank 3
            if (filling && memBus.rdValid)
                retCnt <= retCnt + 1'b1;
            case (state)
                Idle: begin
                    if (reqSeen) begin
                        missFlag <= 1'b0;
                        cacheHit <= 1'b0;
                        err      <= addr[0];
                    end
                end
                CompareTag: begin
                    if (cache.hit)
                        cacheHit <= !missFlag;
                    else
                        missFlag <= 1'b1;
                end
                Reply: begin
                    cacheHit <= 1'b0;
                    err      <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // Read data held until the next hit
    always_ff @(posedge clk) begin
        if ((state == CompareTag) && cache.hit)
            dataOut <= cache.rdData;
    end

    assign done  = (state == Reply);
    assign stall = (state != Idle) && (state != Reply);

    // Memory side
    assign memBus.rd     = issueGo;
    assign memBus.wr     = writeGo;
    assign memBus.addr   = (state == IssueFill)
                         ? {memSysPkg::addrBankWord(addr), issueCnt, 1'b0}
                         : addr;
    assign memBus.wrData = dataIn;

    // Cache side
    assign cache.index  = memSysPkg::addrIndex(addr);
    assign cache.tag    = memSysPkg::addrTag(addr);
    assign cache.offset = filling ? retCnt : memSysPkg::addrOffset(addr);
    assign cache.fillWr = filling && memBus.rdValid;
    assign cache.wordWr = writeGo;     // Store drops it on a miss
    assign cache.wrData = filling ? memBus.rdData : dataIn;

endmodule

`default_nettype wire

// File: src/cacheIf.sv
/*
 * Bus between the cache controller and the cache store.
 * Lookup fields, word and fill write strobes, and the
 * combinational hit and read data coming back.
 */
`default_nettype none

interface cacheIf;

    memSysPkg::indexT  index;
    memSysPkg::tagT    tag;
    memSysPkg::offsetT offset;
    logic              wordWr;   // Write one word, only on hit
    logic              fillWr;   // Fill word, set tag and valid
    memSysPkg::dataT   wrData;
    logic              hit;
    memSysPkg::dataT   rdData;

    modport ctrl (
        output index, tag, offset, wordWr, fillWr, wrData,
        input  hit, rdData
    );

    modport store (
        input  index, tag, offset, wordWr, fillWr, wrData,
        output hit, rdData
    );

endinterface

`default_nettype wire

// File: src/cacheStore.sv
/*
 * Direct-mapped cache arrays.
 * Valid bits, tags and four-word lines, with combinational
 * hit detection and read, plus word and fill writes.
 */
`default_nettype none

module cacheStore (
    input  logic  clk,
    input  logic  rstN,
    cacheIf.store cache
);

    localparam int NumLines     = memSysPkg::NumLines;
    localparam int WordsPerLine = memSysPkg::WordsPerLine;

    logic [NumLines-1:0] validBits;
    memSysPkg::tagT      tags     [NumLines];
    memSysPkg::dataT     lineData [NumLines][WordsPerLine];

    logic lineHit;

    assign lineHit     = validBits[cache.index] && (tags[cache.index] == cache.tag);
    assign cache.hit    = lineHit;
    assign cache.rdData = lineData[cache.index][cache.offset];

    // A line turns valid with its first fill word
    always_ff @(posedge clk) begin
        if (!rstN)
            validBits <= '0;
        else if (cache.fillWr)
            validBits[cache.index] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (cache.fillWr)
            tags[cache.index] <= cache.tag;
    end

    always_ff @(posedge clk) begin
        if (cache.fillWr || (cache.wordWr && lineHit))
            lineData[cache.index][cache.offset] <= cache.wrData;
    end

endmodule

`default_nettype wire

// File: src/memBusIf.sv
/*
 * Bus between the cache controller and the banked main memory.
 * Single-cycle read and write strobes, per-bank busy bits
 * and the delayed read return.
 */
`default_nettype none

interface memBusIf;

    logic               rd;       // Read strobe
    logic               wr;       // Write strobe
    memSysPkg::addrT    addr;
    memSysPkg::dataT    wrData;
    memSysPkg::bankMaskT busy;    // One bit per bank
    memSysPkg::dataT    rdData;
    logic               rdValid;  // Pulses with returned word

    modport ctrl (
        output rd, wr, addr, wrData,
        input  busy, rdData, rdValid
    );

    modport mem (
        input  rd, wr, addr, wrData,
        output busy, rdData, rdValid
    );

endinterface

`default_nettype wire

// File: src/memSysPkg.sv
/*
 * Shared definitions for the cached memory system.
 * Address, data and cache geometry widths, vector typedefs,
 * and helpers that split a byte address into its fields.
 */
`default_nettype none

package memSysPkg;

    localparam int AddrWidth     = 16;
    localparam int DataWidth     = 16;
    localparam int TagWidth      = 5;
    localparam int IndexWidth    = 8;   // 256 lines
    localparam int OffsetWidth   = 2;   // Four words per line
    localparam int NumBanks      = 4;
    localparam int NumLines      = 2 ** IndexWidth;
    localparam int WordsPerLine  = 2 ** OffsetWidth;

    // Bit 0 selects the byte and must be zero
    localparam int OffsetLsb     = 1;
    localparam int IndexLsb      = OffsetLsb + OffsetWidth;
    localparam int TagLsb        = IndexLsb + IndexWidth;
    localparam int BankAddrWidth = AddrWidth - IndexLsb;
    localparam int BankWords     = 2 ** BankAddrWidth;  // 8192

    typedef logic [AddrWidth-1:0]     addrT;
    typedef logic [DataWidth-1:0]     dataT;
    typedef logic [TagWidth-1:0]      tagT;
    typedef logic [IndexWidth-1:0]    indexT;
    typedef logic [OffsetWidth-1:0]   offsetT;
    typedef logic [OffsetWidth-1:0]   bankT;     // Word offset doubles as bank
    typedef logic [BankAddrWidth-1:0] bankAddrT;
    typedef logic [NumBanks-1:0]      bankMaskT;

    function automatic tagT addrTag(addrT a);
        return a[TagLsb +: TagWidth];
    endfunction

    function automatic indexT addrIndex(addrT a);
        return a[IndexLsb +: IndexWidth];
    endfunction

    function automatic offsetT addrOffset(addrT a);
        return a[OffsetLsb +: OffsetWidth];
    endfunction

    function automatic bankT addrBank(addrT a);
        return a[OffsetLsb +: OffsetWidth];
    endfunction

    function automatic bankAddrT addrBankWord(addrT a);
        return a[AddrWidth-1:IndexLsb];
    endfunction

endpackage

`default_nettype wire

// File: src/memSystem.sv
/*
 * Memory system top level.
 * Cache controller, direct-mapped cache store and
 * four-bank interleaved memory.
 */
`default_nettype none

module memSystem #(
    parameter int BankLatency = 2   // Cycles from bank strobe to read return
) (
    input  logic            clk,
    input  logic            rstN,
    input  memSysPkg::addrT addr,
    input  memSysPkg::dataT dataIn,
    input  logic            rd,
    input  logic            wr,
    output memSysPkg::dataT dataOut,
    output logic            done,
    output logic            stall,
    output logic            cacheHit,
    output logic            err
);

    memBusIf memBus ();
    cacheIf  cacheBus ();

    cacheController cacheController_inst (
        .clk      (clk),
        .rstN     (rstN),
        .addr     (addr),
        .dataIn   (dataIn),
        .rd       (rd),
        .wr       (wr),
        .dataOut  (dataOut),
        .done     (done),
        .stall    (stall),
        .cacheHit (cacheHit),
        .err      (err),
        .memBus   (memBus.ctrl),
        .cache    (cacheBus.ctrl)
    );

    cacheStore cacheStore_inst (
        .clk   (clk),
        .rstN  (rstN),
        .cache (cacheBus.store)
    );

    bankedMem #(
        .BankLatency (BankLatency)
    ) bankedMem_inst (
        .clk    (clk),
        .rstN   (rstN),
        .memBus (memBus.mem)
    );

endmodule

`default_nettype wire

// File: verification/memSystemTb.sv
/*
 * Testbench for the cached memory system.
 * Directed tests for reset, hits, misses, write-through,
 * conflict eviction, odd addresses and a seeded random run,
 * checked against a reference memory and tag model.
 */
`default_nettype none

module memSystemTb;

    localparam int NumRequests = 219;              // Sum of requests over all tests
    localparam int CycleLimit  = 40 * NumRequests;

    logic            clk;
    logic            rstN;
    memSysPkg::addrT addr;
    memSysPkg::dataT dataIn;
    logic            rd;
    logic            wr;
    memSysPkg::dataT dataOut;
    logic            done;
    logic            stall;
    logic            cacheHit;
    logic            err;

    // Reference memory holds one entry per 16-bit word
    memSysPkg::dataT refMem   [32768];
    logic            refValid [256];
    memSysPkg::tagT  refTag   [256];

    memSysPkg::dataT gotData;
    logic            gotHit;
    logic            gotErr;
    int              gotLatency;
    int              dataErrors;
    int              flagErrors;
    int              latencyErrors;
    int              cycleCount;
    int              seed;

    memSystem memSystem_inst (
        .clk      (clk),
        .rstN     (rstN),
        .addr     (addr),
        .dataIn   (dataIn),
        .rd       (rd),
        .wr       (wr),
        .dataOut  (dataOut),
        .done     (done),
        .stall    (stall),
        .cacheHit (cacheHit),
        .err      (err)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout after %0d cycles, a request never completed", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Address fields as laid out in the memory map
    function automatic memSysPkg::indexT indexOf(memSysPkg::addrT a);
        return a[10:3];
    endfunction

    function automatic memSysPkg::tagT tagOf(memSysPkg::addrT a);
        return a[15:11];
    endfunction

    task automatic checkData(input memSysPkg::dataT got, input memSysPkg::dataT exp,
                             input string msg);
        if (got !== exp) begin
            dataErrors++;
            $display("[ERROR] %0t: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            flagErrors++;
            $display("[ERROR] %0t: %s: got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic checkLatency(input int got, input int exp, input string msg);
        if (got != exp) begin
            latencyErrors++;
            $display("[ERROR] %0t: %s: got %0d cycles, expected %0d", $time, msg, got, exp);
        end
    endtask

    // Starts on a rising edge and holds the request until done
    task automatic request(input logic isRead, input memSysPkg::addrT a,
                           input memSysPkg::dataT d);
        int k;
        k = 0;
        rd     <= isRead;
        wr     <= !isRead;
        addr   <= a;
        dataIn <= d;
        forever begin
            @(negedge clk);
            if (done)
                break;
            checkFlag(stall, k > 0, "stall before done");
            k++;
        end
        checkFlag(stall, 1'b0, "stall with done");
        gotData    = dataOut;
        gotHit     = cacheHit;
        gotErr     = err;
        gotLatency = k;
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
        @(posedge clk);                            // One idle cycle
    endtask

    task automatic doRead(input memSysPkg::addrT a, input string msg);
        memSysPkg::dataT expData;
        logic            expHit;
        expData = refMem[a[15:1]];
        expHit  = refValid[indexOf(a)] && (refTag[indexOf(a)] == tagOf(a));
        request(1'b1, a, '0);
        if (a[0]) begin
            checkFlag(gotErr, 1'b1, {msg, ": err"});
        end else begin
            checkFlag(gotErr, 1'b0, {msg, ": err"});
            checkData(gotData, expData, {msg, ": data"});
            checkFlag(gotHit, expHit, {msg, ": cacheHit"});
            refValid[indexOf(a)] = 1'b1;           // Read allocates the line
            refTag[indexOf(a)]   = tagOf(a);
        end
    endtask

    task automatic doWrite(input memSysPkg::addrT a, input memSysPkg::dataT d,
                           input string msg);
        request(1'b0, a, d);
        if (a[0]) begin
            checkFlag(gotErr, 1'b1, {msg, ": err"});
        end else begin
            checkFlag(gotErr, 1'b0, {msg, ": err"});
            refMem[a[15:1]] = d;                   // Cached copy follows memory
        end
    endtask

    task automatic resetTest();
        @(negedge clk);
        checkFlag(done, 1'b0, "done after reset");
        checkFlag(stall, 1'b0, "stall after reset");
        checkFlag(err, 1'b0, "err after reset");
        checkFlag(cacheHit, 1'b0, "cacheHit after reset");
        @(posedge clk);
        doRead(16'h0040, "first read");
        doRead(16'h0040, "read hit");
        checkLatency(gotLatency, 2, "read hit latency");
    endtask

    task automatic missThenHitTest();
        doWrite(16'h1234, 16'hBEEF, "write before miss");
        doRead(16'h1234, "read miss");
        doRead(16'h1234, "read hit same word");
        doRead(16'h1230, "read hit other word");
    endtask

    task automatic writeThroughTest();
        doWrite(16'h1232, 16'h5A5A, "write present line");
        doRead(16'h1232, "read after present write");
        doWrite(16'h2A08, 16'hC0DE, "write absent line");
        doRead(16'h2A08, "read after absent write");
    endtask

    // Both addresses share index 3 with tags 1 and 15
    task automatic conflictTest();
        doWrite(16'h0818, 16'h1111, "write first tag");
        doWrite(16'h7818, 16'h2222, "write second tag");
        doRead(16'h0818, "conflict read A");
        doRead(16'h7818, "conflict read B");
        doRead(16'h0818, "conflict read A again");
        doRead(16'h7818, "conflict read B again");
    endtask

    task automatic oddAddressTest();
        doWrite(16'h0819, 16'hDEAD, "odd write");
        checkLatency(gotLatency, 1, "odd write latency");
        doRead(16'h0819, "odd read");
        doRead(16'h0818, "aligned read after odd");
    endtask

    task automatic randomTest();
        memSysPkg::tagT    t;
        memSysPkg::indexT  idx;
        memSysPkg::offsetT off;
        memSysPkg::addrT   a;
        memSysPkg::dataT   d;
        logic              isWrite;
        for (int i = 0; i < 200; i++) begin
            t       = memSysPkg::tagT'($random(seed) & 3);
            idx     = memSysPkg::indexT'(8'h20 + ($random(seed) & 3));
            off     = memSysPkg::offsetT'($random(seed));
            a       = {t, idx, off, 1'b0};
            d       = memSysPkg::dataT'($random(seed));
            isWrite = ($random(seed) & 1) != 0;
            if (isWrite)
                doWrite(a, d, "random write");
            else
                doRead(a, "random read");
        end
    endtask

    initial begin
        clk           = 1'b0;
        rstN          = 1'b0;
        addr          = '0;
        dataIn        = '0;
        rd            = 1'b0;
        wr            = 1'b0;
        dataErrors    = 0;
        flagErrors    = 0;
        latencyErrors = 0;
        cycleCount    = 0;
        seed          = 61;
        for (int w = 0; w < 32768; w++)
            refMem[w] = '0;
        for (int l = 0; l < 256; l++) begin
            refValid[l] = 1'b0;
            refTag[l]   = '0;
        end

        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        resetTest();
        missThenHitTest();
        writeThroughTest();
        conflictTest();
        oddAddressTest();
        randomTest();

        $display("Errors: %0d data, %0d flag, %0d latency",
                 dataErrors, flagErrors, latencyErrors);
        if (dataErrors + flagErrors + latencyErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
